// ==== design/sniff_consts.svh ====
// Register map assumes 8-bit Wishbone data, up to 16 registers of up to 8 bytes, FIFO depth a power of two
`ifndef SNIFF_CONSTS_SVH
`define SNIFF_CONSTS_SVH

// FIFO sizing
`define SNIFF_FIFO_DEPTH 16
`define SNIFF_FIFO_THRESH 14

// Wishbone address split into register number and byte index
`define SNIFF_ADR_W 7
`define SNIFF_BYTE_IDX_W 3

// Register numbers
`define REG_ARM 0
`define REG_TIMESTAMPS_DISABLE 1
`define REG_PATTERN 2
`define REG_PATTERN_MASK 3
`define REG_PATTERN_BYTES 4
`define REG_TRIGGER_ENABLE 5
`define REG_CAPTURE_LEN 6
`define REG_FIFO_STAT 7
`define REG_FIFO_RD 8

// Pattern and mask width in bytes
`define PATTERN_BYTES 8

// Status byte bit positions; bits 1 and 2 read as zero
`define FIFO_STAT_EMPTY 0
`define FIFO_STAT_FULL 3
`define FIFO_STAT_OVERFLOW_BLOCKED 4
`define FIFO_STAT_FULL_THRESHOLD 5

// Data field of the stream-empty marker
`define STRM_EMPTY_DATA 8'hFF

`endif

// ==== design/sniff_entry_packer.sv ====
// Capture side has no back-pressure; events seen while the FIFO is near full are lost
`timescale 1ns/1ns
`default_nettype none

module sniff_entry_packer (
   input  wire                  cwusb_clk,
   input  wire                  reset_i,
   input  wire                  capture_wr_i,
   input  wire sniff_pkg::fe_cmd_t capture_cmd_i,
   input  wire [15:0]           capture_time_i,
   input  wire [7:0]            capture_data_i,
   input  wire [4:0]            capture_stat_i,
   input  wire                  almost_full_i,
   input  wire                  arm_set_i,
   output logic                 push_o,
   output sniff_pkg::fe_entry_u push_entry_o,
   output logic                 overflow_blocked_o
);

   import sniff_pkg::*;

   logic accept;
   logic blocked;

   assign accept  = capture_wr_i & ~almost_full_i;
   assign blocked = capture_wr_i & almost_full_i;

   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         push_o             <= 1'b0;
         overflow_blocked_o <= 1'b0;
      end else begin
         push_o <= accept;
         // Sticky until the next arm
         if (blocked) begin
            overflow_blocked_o <= 1'b1;
         end else if (arm_set_i) begin
            overflow_blocked_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge cwusb_clk) begin
      if (accept) begin
         case (capture_cmd_i)
            DATA: push_entry_o.short_view <= '{cmd: DATA, short_time: capture_time_i[2:0],
                                               stat: capture_stat_i, data: capture_data_i};
            STAT: push_entry_o.short_view <= '{cmd: STAT, short_time: capture_time_i[2:0],
                                               stat: capture_stat_i, data: 8'h00};
            // Full timestamp
            default: push_entry_o.long_view <= '{cmd: capture_cmd_i,
                                                 full_time: capture_time_i};
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== design/sniff_fifo.sv ====
// DEPTH must be a power of two; almost-full counts the entry written in the same cycle
`timescale 1ns/1ns
`default_nettype none
`include "sniff_consts.svh"

module sniff_fifo #(
   parameter int DEPTH = `SNIFF_FIFO_DEPTH
) (
   input  wire                      cwusb_clk,
   input  wire                      reset_i,
   input  wire                      push_i,
   input  wire sniff_pkg::fe_entry_u push_entry_i,
   input  wire                      pop_i,
   output sniff_pkg::fe_entry_u     head_entry_o,
   output logic                     empty_o,
   output logic                     full_o,
   output logic                     almost_full_o
);

   import sniff_pkg::*;

   localparam int AW = $clog2(DEPTH);

   fe_entry_u     mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic [AW:0]   count_next;

   assign count_next = count + (AW+1)'(push_i) - (AW+1)'(pop_i);

   always_ff @(posedge cwusb_clk) begin
      if (push_i) begin
         mem[wr_ptr] <= push_entry_i;
      end
   end

   // Pointers wrap naturally at DEPTH
   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop_i) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count_next;
      end
   end

   // Show-ahead head
   assign head_entry_o = mem[rd_ptr];

   assign empty_o = (count == '0);
   assign full_o  = (count == (AW+1)'(DEPTH));

   // Includes an in-flight push so back-to-back writes stop exactly at the threshold
   assign almost_full_o = (count_next >= (AW+1)'(`SNIFF_FIFO_THRESH));

   // Packer and reader must respect the flags
   a_no_xrun: assert property (@(posedge cwusb_clk) disable iff (reset_i)
      !(pop_i && empty_o) && !(push_i && full_o));

endmodule

`default_nettype wire

// ==== design/sniff_fifo_reader.sv ====
// Host reads each entry as bytes 0, 1, 2 in that order; byte 3 reads zero
`timescale 1ns/1ns
`default_nettype none
`include "sniff_consts.svh"

module sniff_fifo_reader (
   input  wire                      cwusb_clk,
   input  wire                      reset_i,
   input  wire                      fifo_byte_rd_i,
   input  wire [1:0]                fifo_byte_sel_i,
   input  wire                      arm_set_i,
   input  wire                      arm_i,
   input  wire sniff_pkg::fe_entry_u head_entry_i,
   input  wire                      empty_i,
   output logic                     pop_o,
   output logic [7:0]               fifo_byte_o,
   output logic                     capture_arm_o
);

   import sniff_pkg::*;

   fe_entry_u marker;
   fe_entry_u src_entry;
   fe_entry_u hold_q;
   logic      rd_first;
   logic      flushing;
   logic      arm_q;

   // Stream-empty marker
   always_comb begin
      marker = '0;
      marker.short_view.cmd  = STRM;
      marker.short_view.data = `STRM_EMPTY_DATA;
   end

   assign src_entry = empty_i ? marker : head_entry_i;
   assign rd_first  = fifo_byte_rd_i & (fifo_byte_sel_i == 2'd0);
   assign pop_o     = ~empty_i & (rd_first | flushing);

   always_ff @(posedge cwusb_clk) begin
      if (rd_first) begin
         hold_q <= src_entry;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Flush on arm
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         flushing <= 1'b0;
         arm_q    <= 1'b0;
      end else begin
         arm_q <= arm_i;
         if (arm_set_i) begin
            flushing <= 1'b1;
         end else if (empty_i) begin
            flushing <= 1'b0;
         end
      end
   end

   assign capture_arm_o = arm_q & ~flushing;

   // Byte 0 straight from the source, the rest from the held copy
   always_comb begin
      case (fifo_byte_sel_i)
         2'd0:    fifo_byte_o = src_entry[7:0];
         2'd1:    fifo_byte_o = hold_q[15:8];
         2'd2:    fifo_byte_o = {6'b0, hold_q[17:16]};
         default: fifo_byte_o = 8'h00;
      endcase
   end

   // Arm shows only once the flush has drained the FIFO
   a_arm_after_flush: assert property (@(posedge cwusb_clk) disable iff (reset_i)
      $rose(capture_arm_o) |-> empty_i);

endmodule

`default_nettype wire

// ==== design/sniff_pkg.sv ====
// Entry layout is fixed at 18 bits with the command always in the top two bits of both views
`default_nettype none

package sniff_pkg;

   // Command carried in every FIFO entry
   typedef enum logic [1:0] {
      DATA = 2'd0,
      STAT = 2'd1,
      TIME = 2'd2,
      STRM = 2'd3
   } fe_cmd_t;

   // Data and status entries
   typedef struct packed {
      fe_cmd_t    cmd;
      logic [2:0] short_time;
      logic [4:0] stat;
      logic [7:0] data;
   } fe_short_t;

   // Full-time entry
   typedef struct packed {
      fe_cmd_t     cmd;
      logic [15:0] full_time;
   } fe_long_t;

   // One FIFO word, decoded by its command
   typedef union packed {
      fe_short_t short_view;
      fe_long_t  long_view;
   } fe_entry_u;

endpackage

`default_nettype wire

// ==== design/sniff_reg_bank.sv ====
// Wishbone classic slave, 8-bit data; the master holds cyc and stb until ack, which lasts one cycle
`timescale 1ns/1ns
`default_nettype none
`include "sniff_consts.svh"

module sniff_reg_bank (
   input  wire                         cwusb_clk,
   input  wire                         reset_i,
   input  wire                         wb_cyc_i,
   input  wire                         wb_stb_i,
   input  wire                         wb_we_i,
   input  wire [`SNIFF_ADR_W-1:0]      wb_adr_i,
   input  wire [7:0]                   wb_dat_i,
   output logic [7:0]                  wb_dat_o,
   output logic                        wb_ack_o,
   input  wire                         capture_started_i,
   input  wire                         fifo_empty_i,
   input  wire                         fifo_full_i,
   input  wire                         fifo_almost_full_i,
   input  wire                         overflow_blocked_i,
   input  wire [7:0]                   fifo_byte_i,
   input  wire                         capture_arm_i,
   output logic                        arm_set_o,
   output logic                        arm_o,
   output logic                        capture_arm_o,
   output logic                        fifo_byte_rd_o,
   output logic [1:0]                  fifo_byte_sel_o,
   output logic                        timestamps_disable_o,
   output logic [8*`PATTERN_BYTES-1:0] pattern_o,
   output logic [8*`PATTERN_BYTES-1:0] pattern_mask_o,
   output logic [7:0]                  pattern_bytes_o,
   output logic                        trigger_enable_o,
   output logic [15:0]                 capture_len_o
);

   logic [`SNIFF_ADR_W-`SNIFF_BYTE_IDX_W-1:0] reg_num;
   logic [`SNIFF_BYTE_IDX_W-1:0]              byte_idx;
   logic                                      wr_acc;
   logic                                      rd_acc;
   logic                                      arm_q;
   logic [7:0]                                fifo_stat;

   assign reg_num  = wb_adr_i[`SNIFF_ADR_W-1:`SNIFF_BYTE_IDX_W];
   assign byte_idx = wb_adr_i[`SNIFF_BYTE_IDX_W-1:0];

   // Access happens in the ack cycle
   assign wr_acc = wb_ack_o & wb_cyc_i & wb_stb_i & wb_we_i;
   assign rd_acc = wb_ack_o & wb_cyc_i & wb_stb_i & ~wb_we_i;

   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         wb_ack_o <= 1'b0;
      end else begin
         wb_ack_o <= wb_cyc_i & wb_stb_i & ~wb_ack_o;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Configuration registers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         timestamps_disable_o <= 1'b0;
         pattern_o            <= '0;
         pattern_mask_o       <= '0;
         pattern_bytes_o      <= '0;
         trigger_enable_o     <= 1'b0;
         capture_len_o        <= '0;
      end else if (wr_acc) begin
         case (reg_num)
            `REG_TIMESTAMPS_DISABLE: timestamps_disable_o <= wb_dat_i[0];
            `REG_PATTERN:            pattern_o[byte_idx*8 +: 8] <= wb_dat_i;
            `REG_PATTERN_MASK:       pattern_mask_o[byte_idx*8 +: 8] <= wb_dat_i;
            `REG_PATTERN_BYTES:      pattern_bytes_o <= wb_dat_i;
            `REG_TRIGGER_ENABLE:     trigger_enable_o <= wb_dat_i[0];
            // Two bytes only
            `REG_CAPTURE_LEN:        capture_len_o[byte_idx[0]*8 +: 8] <= wb_dat_i;
            default: ;
         endcase
      end
   end

   // Arm flag: set by host, cleared once the trigger path starts capturing
   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         arm_q <= 1'b0;
      end else if (wr_acc && (reg_num == `REG_ARM)) begin
         arm_q <= wb_dat_i[0];
      end else if (capture_started_i) begin
         arm_q <= 1'b0;
      end
   end

   assign arm_set_o     = wr_acc & (reg_num == `REG_ARM) & wb_dat_i[0];
   assign arm_o         = arm_q;
   assign capture_arm_o = capture_arm_i;

   //////////////////////////////////////////////////////////////////////
   // Read side
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      fifo_stat = '0;
      fifo_stat[`FIFO_STAT_EMPTY]            = fifo_empty_i;
      fifo_stat[`FIFO_STAT_FULL]             = fifo_full_i;
      fifo_stat[`FIFO_STAT_OVERFLOW_BLOCKED] = overflow_blocked_i;
      fifo_stat[`FIFO_STAT_FULL_THRESHOLD]   = fifo_almost_full_i & ~fifo_full_i;
   end

   assign fifo_byte_rd_o  = rd_acc & (reg_num == `REG_FIFO_RD);
   assign fifo_byte_sel_o = byte_idx[1:0];

   always_comb begin
      case (reg_num)
         `REG_ARM:                wb_dat_o = {7'b0, arm_q};
         `REG_TIMESTAMPS_DISABLE: wb_dat_o = {7'b0, timestamps_disable_o};
         `REG_PATTERN:            wb_dat_o = pattern_o[byte_idx*8 +: 8];
         `REG_PATTERN_MASK:       wb_dat_o = pattern_mask_o[byte_idx*8 +: 8];
         `REG_PATTERN_BYTES:      wb_dat_o = pattern_bytes_o;
         `REG_TRIGGER_ENABLE:     wb_dat_o = {7'b0, trigger_enable_o};
         `REG_CAPTURE_LEN:        wb_dat_o = capture_len_o[byte_idx[0]*8 +: 8];
         `REG_FIFO_STAT:          wb_dat_o = fifo_stat;
         `REG_FIFO_RD:            wb_dat_o = fifo_byte_i;
         default:                 wb_dat_o = 8'h00;
      endcase
   end

endmodule

`default_nettype wire

// ==== design/usb_sniffer_top.sv ====
// Single clock domain; capture events arrive already in cwusb_clk
`timescale 1ns/1ns
`default_nettype none
`include "sniff_consts.svh"

module usb_sniffer_top (
   input  wire                         cwusb_clk,
   input  wire                         reset_i,
   input  wire                         wb_cyc_i,
   input  wire                         wb_stb_i,
   input  wire                         wb_we_i,
   input  wire [`SNIFF_ADR_W-1:0]      wb_adr_i,
   input  wire [7:0]                   wb_dat_i,
   output wire [7:0]                   wb_dat_o,
   output wire                         wb_ack_o,
   input  wire                         capture_wr_i,
   input  wire sniff_pkg::fe_cmd_t     capture_cmd_i,
   input  wire [15:0]                  capture_time_i,
   input  wire [7:0]                   capture_data_i,
   input  wire [4:0]                   capture_stat_i,
   input  wire                         capture_started_i,
   output wire                         capture_arm_o,
   output wire                         timestamps_disable_o,
   output wire [8*`PATTERN_BYTES-1:0]  pattern_o,
   output wire [8*`PATTERN_BYTES-1:0]  pattern_mask_o,
   output wire [7:0]                   pattern_bytes_o,
   output wire                         trigger_enable_o,
   output wire [15:0]                  capture_len_o,
   output wire                         fifo_full_o,
   output wire                         overflow_blocked_o
);

   import sniff_pkg::*;

   logic       push;
   fe_entry_u  push_entry;
   logic       pop;
   fe_entry_u  head_entry;
   logic       fifo_empty;
   logic       fifo_almost_full;
   logic       arm_set;
   logic       arm_flag;
   logic       reader_arm;
   logic       fifo_byte_rd;
   logic [1:0] fifo_byte_sel;
   logic [7:0] fifo_byte;

   sniff_reg_bank u_reg_bank (
      .cwusb_clk            (cwusb_clk),
      .reset_i              (reset_i),
      .wb_cyc_i             (wb_cyc_i),
      .wb_stb_i             (wb_stb_i),
      .wb_we_i              (wb_we_i),
      .wb_adr_i             (wb_adr_i),
      .wb_dat_i             (wb_dat_i),
      .wb_dat_o             (wb_dat_o),
      .wb_ack_o             (wb_ack_o),
      .capture_started_i    (capture_started_i),
      .fifo_empty_i         (fifo_empty),
      .fifo_full_i          (fifo_full_o),
      .fifo_almost_full_i   (fifo_almost_full),
      .overflow_blocked_i   (overflow_blocked_o),
      .fifo_byte_i          (fifo_byte),
      .capture_arm_i        (reader_arm),
      .arm_set_o            (arm_set),
      .arm_o                (arm_flag),
      .capture_arm_o        (capture_arm_o),
      .fifo_byte_rd_o       (fifo_byte_rd),
      .fifo_byte_sel_o      (fifo_byte_sel),
      .timestamps_disable_o (timestamps_disable_o),
      .pattern_o            (pattern_o),
      .pattern_mask_o       (pattern_mask_o),
      .pattern_bytes_o      (pattern_bytes_o),
      .trigger_enable_o     (trigger_enable_o),
      .capture_len_o        (capture_len_o)
   );

   sniff_entry_packer u_packer (
      .cwusb_clk          (cwusb_clk),
      .reset_i            (reset_i),
      .capture_wr_i       (capture_wr_i),
      .capture_cmd_i      (capture_cmd_i),
      .capture_time_i     (capture_time_i),
      .capture_data_i     (capture_data_i),
      .capture_stat_i     (capture_stat_i),
      .almost_full_i      (fifo_almost_full),
      .arm_set_i          (arm_set),
      .push_o             (push),
      .push_entry_o       (push_entry),
      .overflow_blocked_o (overflow_blocked_o)
   );

   sniff_fifo u_fifo (
      .cwusb_clk     (cwusb_clk),
      .reset_i       (reset_i),
      .push_i        (push),
      .push_entry_i  (push_entry),
      .pop_i         (pop),
      .head_entry_o  (head_entry),
      .empty_o       (fifo_empty),
      .full_o        (fifo_full_o),
      .almost_full_o (fifo_almost_full)
   );

   sniff_fifo_reader u_reader (
      .cwusb_clk       (cwusb_clk),
      .reset_i         (reset_i),
      .fifo_byte_rd_i  (fifo_byte_rd),
      .fifo_byte_sel_i (fifo_byte_sel),
      .arm_set_i       (arm_set),
      .arm_i           (arm_flag),
      .head_entry_i    (head_entry),
      .empty_i         (fifo_empty),
      .pop_o           (pop),
      .fifo_byte_o     (fifo_byte),
      .capture_arm_o   (reader_arm)
   );

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+design
design/sniff_pkg.sv
design/sniff_reg_bank.sv
design/sniff_entry_packer.sv
design/sniff_fifo.sv
design/sniff_fifo_reader.sv
design/usb_sniffer_top.sv
verification/sniff_checker.sv
verification/tb_usb_sniffer.sv

// ==== verification/sniff_checker.sv ====
// Compares DUT outputs with values from the testbench model; read data is taken in the ack cycle
`timescale 1ns/1ns
`default_nettype none
`include "sniff_consts.svh"

module sniff_checker (
   input  wire                        cwusb_clk,
   input  wire                        we_i,
   input  wire                        ack_i,
   input  wire [7:0]                  dat_i,
   input  wire                        arm_i,
   input  wire                        tsd_i,
   input  wire [8*`PATTERN_BYTES-1:0] pattern_i,
   input  wire [8*`PATTERN_BYTES-1:0] mask_i,
   input  wire [7:0]                  pbytes_i,
   input  wire                        trig_i,
   input  wire [15:0]                 len_i,
   input  wire                        full_i,
   input  wire                        ovf_i,
   output int                         check_count_o,
   output int                         error_count_o
);

   logic [7:0] rd_data;

   initial begin
      check_count_o = 0;
      error_count_o = 0;
   end

   // Last byte returned by a Wishbone read
   always @(posedge cwusb_clk) begin
      if (ack_i && !we_i) begin
         rd_data <= dat_i;
      end
   end

   task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
      check_count_o++;
      if (got !== exp) begin
         error_count_o++;
         $display("mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic check_read(input string name, input logic [7:0] exp);
      compare(name, rd_data, exp);
   endtask

   task automatic check_config(input logic [63:0] exp_pattern, input logic [63:0] exp_mask,
                               input logic [7:0] exp_pbytes, input logic exp_trig,
                               input logic [15:0] exp_len, input logic exp_tsd);
      compare("pattern_o", pattern_i, exp_pattern);
      compare("pattern_mask_o", mask_i, exp_mask);
      compare("pattern_bytes_o", pbytes_i, exp_pbytes);
      compare("trigger_enable_o", trig_i, exp_trig);
      compare("capture_len_o", len_i, exp_len);
      compare("timestamps_disable_o", tsd_i, exp_tsd);
   endtask

   task automatic check_pins(input logic exp_arm, input logic exp_ovf, input logic exp_full);
      compare("capture_arm_o", arm_i, exp_arm);
      compare("overflow_blocked_o", ovf_i, exp_ovf);
      compare("fifo_full_o", full_i, exp_full);
   endtask

   task automatic fail(input string msg);
      check_count_o++;
      error_count_o++;
      $display("error at %0t ns: %s", $time, msg);
   endtask

endmodule

`default_nettype wire

// ==== verification/tb_usb_sniffer.sv ====
// Inputs change on the falling edge; random values come from seed 16; each Wishbone access is blocking
`timescale 1ns/1ns
`default_nettype none
`include "sniff_consts.svh"

module tb_usb_sniffer;

   import sniff_pkg::*;

   // Wishbone accesses and capture events over all five tests
   localparam int NUM_TRANS       = 42 + 4 + 41 + 4 + 72;
   localparam int WATCHDOG_CYCLES = NUM_TRANS * 20;

   logic                         cwusb_clk = 1'b0;
   logic                         reset_i;
   logic                         wb_cyc_i;
   logic                         wb_stb_i;
   logic                         wb_we_i;
   logic [`SNIFF_ADR_W-1:0]      wb_adr_i;
   logic [7:0]                   wb_dat_i;
   wire  [7:0]                   wb_dat_o;
   wire                          wb_ack_o;
   logic                         capture_wr_i;
   fe_cmd_t                      capture_cmd_i;
   logic [15:0]                  capture_time_i;
   logic [7:0]                   capture_data_i;
   logic [4:0]                   capture_stat_i;
   logic                         capture_started_i;
   wire                          capture_arm_o;
   wire                          timestamps_disable_o;
   wire  [8*`PATTERN_BYTES-1:0]  pattern_o;
   wire  [8*`PATTERN_BYTES-1:0]  pattern_mask_o;
   wire  [7:0]                   pattern_bytes_o;
   wire                          trigger_enable_o;
   wire  [15:0]                  capture_len_o;
   wire                          fifo_full_o;
   wire                          overflow_blocked_o;

   int          check_count;
   int          err_count;
   int          err_at_start;
   int          tests_run;
   integer      seed;
   logic [17:0] model [$];
   logic        model_ovf;

   always #20 cwusb_clk = ~cwusb_clk;

   usb_sniffer_top DUT (.*);

   sniff_checker u_checker (
      .cwusb_clk     (cwusb_clk),
      .we_i          (wb_we_i),
      .ack_i         (wb_ack_o),
      .dat_i         (wb_dat_o),
      .arm_i         (capture_arm_o),
      .tsd_i         (timestamps_disable_o),
      .pattern_i     (pattern_o),
      .mask_i        (pattern_mask_o),
      .pbytes_i      (pattern_bytes_o),
      .trig_i        (trigger_enable_o),
      .len_i         (capture_len_o),
      .full_i        (fifo_full_o),
      .ovf_i         (overflow_blocked_o),
      .check_count_o (check_count),
      .error_count_o (err_count)
   );

   //////////////////////////////////////////////////////////////////////
   // Expected values
   //////////////////////////////////////////////////////////////////////

   function automatic logic [17:0] expected_entry(input logic [1:0] cmd, input logic [15:0] t,
                                                  input logic [7:0] d, input logic [4:0] s);
      case (cmd)
         2'd0:    expected_entry = {2'd0, t[2:0], s, d};
         2'd1:    expected_entry = {2'd1, t[2:0], s, 8'h00};
         default: expected_entry = {2'd2, t};
      endcase
   endfunction

   function automatic logic [7:0] expected_status();
      logic [7:0] st;
      st = 8'h00;
      st[`FIFO_STAT_EMPTY]            = (model.size() == 0);
      st[`FIFO_STAT_FULL]             = (model.size() == `SNIFF_FIFO_DEPTH);
      st[`FIFO_STAT_OVERFLOW_BLOCKED] = model_ovf;
      st[`FIFO_STAT_FULL_THRESHOLD]   = (model.size() >= `SNIFF_FIFO_THRESH) &&
                                        (model.size() < `SNIFF_FIFO_DEPTH);
      expected_status = st;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Bus and capture drivers, all entered on a falling edge
   //////////////////////////////////////////////////////////////////////

   task automatic wb_access(input logic we, input logic [3:0] reg_n, input logic [2:0] idx,
                            input logic [7:0] wdata);
      int waited;
      waited   = 0;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = {reg_n, idx};
      wb_dat_i = wdata;
      @(negedge cwusb_clk);
      while (!wb_ack_o && waited < 8) begin
         @(negedge cwusb_clk);
         waited++;
      end
      if (!wb_ack_o) begin
         u_checker.fail("Wishbone access was never acknowledged");
      end
      // Hold the request through the edge that ends the ack cycle
      @(negedge cwusb_clk);
      // Ack lasts exactly one cycle
      u_checker.compare("wb_ack_o", wb_ack_o, 1'b0);
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic reg_write(input logic [3:0] reg_n, input logic [2:0] idx,
                            input logic [7:0] wdata);
      wb_access(1'b1, reg_n, idx, wdata);
   endtask

   task automatic reg_read(input logic [3:0] reg_n, input logic [2:0] idx, input string name,
                           input logic [7:0] exp);
      wb_access(1'b0, reg_n, idx, 8'h00);
      u_checker.check_read(name, exp);
   endtask

   task automatic read_entry(input logic [17:0] exp);
      reg_read(`REG_FIFO_RD, 3'd0, "fifo byte 0", exp[7:0]);
      reg_read(`REG_FIFO_RD, 3'd1, "fifo byte 1", exp[15:8]);
      reg_read(`REG_FIFO_RD, 3'd2, "fifo byte 2", {6'b0, exp[17:16]});
   endtask

   task automatic send_event(input logic [1:0] cmd);
      logic [15:0] t;
      logic [7:0]  d;
      logic [4:0]  s;
      t = $random(seed);
      d = $random(seed);
      s = $random(seed);
      capture_wr_i   = 1'b1;
      capture_cmd_i  = fe_cmd_t'(cmd);
      capture_time_i = t;
      capture_data_i = d;
      capture_stat_i = s;
      // Events at or above the threshold are lost
      if (model.size() >= `SNIFF_FIFO_THRESH) begin
         model_ovf = 1'b1;
      end else begin
         model.push_back(expected_entry(cmd, t, d, s));
      end
      @(negedge cwusb_clk);
      capture_wr_i = 1'b0;
   endtask

   task automatic wait_arm();
      int n;
      n = 0;
      while (!capture_arm_o && n < 40) begin
         @(negedge cwusb_clk);
         n++;
      end
      if (!capture_arm_o) begin
         u_checker.fail("capture_arm_o never rose after arming");
      end
   endtask

   task automatic start_test();
      err_at_start = err_count;
   endtask

   task automatic end_test(input string name);
      @(negedge cwusb_clk);
      tests_run++;
      $display("test %s finished with %0d errors", name, err_count - err_at_start);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      int          i;
      logic [31:0] r;
      logic [7:0]  b;
      logic [63:0] exp_pattern;
      logic [63:0] exp_mask;
      logic [7:0]  exp_pbytes;
      logic        exp_trig;
      logic [15:0] exp_len;
      logic        exp_tsd;
      seed              = 16;
      tests_run         = 0;
      model_ovf         = 1'b0;
      reset_i           = 1'b1;
      wb_cyc_i          = 1'b0;
      wb_stb_i          = 1'b0;
      wb_we_i           = 1'b0;
      wb_adr_i          = '0;
      wb_dat_i          = 8'h00;
      capture_wr_i      = 1'b0;
      capture_cmd_i     = DATA;
      capture_time_i    = 16'h0000;
      capture_data_i    = 8'h00;
      capture_stat_i    = 5'h00;
      capture_started_i = 1'b0;
      repeat (10) @(negedge cwusb_clk);
      reset_i = 1'b0;
      @(negedge cwusb_clk);

      // Configuration registers
      start_test();
      for (i = 0; i < 8; i++) begin
         b = $random(seed);
         exp_pattern[i*8 +: 8] = b;
         reg_write(`REG_PATTERN, i[2:0], b);
         b = $random(seed);
         exp_mask[i*8 +: 8] = b;
         reg_write(`REG_PATTERN_MASK, i[2:0], b);
      end
      exp_pbytes = $random(seed);
      reg_write(`REG_PATTERN_BYTES, 3'd0, exp_pbytes);
      b = $random(seed);
      exp_trig = b[0];
      reg_write(`REG_TRIGGER_ENABLE, 3'd0, b);
      exp_len = $random(seed);
      reg_write(`REG_CAPTURE_LEN, 3'd0, exp_len[7:0]);
      reg_write(`REG_CAPTURE_LEN, 3'd1, exp_len[15:8]);
      b = $random(seed);
      exp_tsd = b[0];
      reg_write(`REG_TIMESTAMPS_DISABLE, 3'd0, b);
      for (i = 0; i < 8; i++) begin
         reg_read(`REG_PATTERN, i[2:0], $sformatf("pattern byte %0d", i), exp_pattern[i*8 +: 8]);
         reg_read(`REG_PATTERN_MASK, i[2:0], $sformatf("mask byte %0d", i), exp_mask[i*8 +: 8]);
      end
      reg_read(`REG_PATTERN_BYTES, 3'd0, "pattern bytes", exp_pbytes);
      reg_read(`REG_TRIGGER_ENABLE, 3'd0, "trigger enable", {7'b0, exp_trig});
      reg_read(`REG_CAPTURE_LEN, 3'd0, "capture len byte 0", exp_len[7:0]);
      reg_read(`REG_CAPTURE_LEN, 3'd1, "capture len byte 1", exp_len[15:8]);
      reg_read(`REG_TIMESTAMPS_DISABLE, 3'd0, "timestamps disable", {7'b0, exp_tsd});
      u_checker.check_config(exp_pattern, exp_mask, exp_pbytes, exp_trig, exp_len, exp_tsd);
      end_test("config_regs");

      // Arm, then clear it with a capture start
      start_test();
      reg_write(`REG_ARM, 3'd0, 8'h01);
      wait_arm();
      reg_read(`REG_ARM, 3'd0, "arm flag", 8'h01);
      capture_started_i = 1'b1;
      @(negedge cwusb_clk);
      capture_started_i = 1'b0;
      reg_read(`REG_ARM, 3'd0, "arm flag", 8'h00);
      u_checker.check_pins(1'b0, 1'b0, 1'b0);
      end_test("arming");

      start_test();
      for (i = 0; i < 10; i++) begin
         r = $random(seed);
         send_event(r % 3);
      end
      while (model.size() > 0) begin
         read_entry(model.pop_front());
      end
      reg_read(`REG_FIFO_STAT, 3'd0, "fifo status", expected_status());
      end_test("packing");

      start_test();
      reg_read(`REG_FIFO_RD, 3'd0, "marker byte 0", `STRM_EMPTY_DATA);
      reg_read(`REG_FIFO_RD, 3'd1, "marker byte 1", 8'h00);
      reg_read(`REG_FIFO_RD, 3'd2, "marker byte 2", {6'b0, STRM});
      reg_read(`REG_FIFO_STAT, 3'd0, "fifo status", expected_status());
      end_test("empty_marker");

      // Overflow, drain, refill, then flush by re-arming
      start_test();
      for (i = 0; i < 20; i++) begin
         r = $random(seed);
         send_event(r % 3);
      end
      u_checker.check_pins(1'b0, 1'b1, 1'b0);
      reg_read(`REG_FIFO_STAT, 3'd0, "fifo status", expected_status());
      while (model.size() > 0) begin
         read_entry(model.pop_front());
      end
      reg_read(`REG_FIFO_STAT, 3'd0, "fifo status", expected_status());
      for (i = 0; i < 5; i++) begin
         r = $random(seed);
         send_event(r % 3);
      end
      reg_read(`REG_FIFO_STAT, 3'd0, "fifo status", expected_status());
      reg_write(`REG_ARM, 3'd0, 8'h01);
      model.delete();
      model_ovf = 1'b0;
      wait_arm();
      u_checker.check_pins(1'b1, 1'b0, 1'b0);
      reg_read(`REG_FIFO_STAT, 3'd0, "fifo status", expected_status());
      end_test("overflow");

      $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, err_count);
      if (err_count == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   // Watchdog
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge cwusb_clk);
      $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire
